// ==== include/mbus_defines.svh ====
`ifndef MBUS_DEFINES_SVH
`define MBUS_DEFINES_SVH

// ==================================================
// frame layout
// ==================================================
`define MBUS_ADDR_WIDTH   8
`define MBUS_DATA_WIDTH   32
`define MBUS_DYNA_WIDTH   4
`define MBUS_FRAME_BITS   42      // start, address, data and stop

// ==================================================
// addressing and timing
// ==================================================
`define MBUS_BCAST_PREFIX 4'hF    // top nibble that every layer accepts
`define MBUS_RESP_WINDOW  128     // cycles to wait for our own frame to return

`endif

// ==== rtl/mbus_pkg.sv ====
`default_nettype none

package mbus_pkg;

   // command field in data[31:28] of frames on channel F0
   typedef enum logic [3:0] {
      CMD_ENUM  = 4'd2,
      CMD_INVAL = 4'd3
   } mbus_cmd_t;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_SHIFTING,
      RX_DONE
   } mbus_rx_state_t;

   typedef enum logic {
      TX_IDLE,
      TX_SENDING
   } mbus_tx_state_t;

   typedef enum logic [1:0] {
      RES_IDLE,
      RES_WAITING,
      RES_REPORT
   } mbus_res_state_t;

endpackage

`default_nettype wire

// ==== rtl/mbus_rx_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mbus_defines.svh"

module mbus_rx_decode
   import mbus_pkg::*;
#(
   parameter logic [19:0] ADDRESS = 20'h12345
) (
   input  wire                         clk_in,
   input  wire                         rst_n,
   input  wire                         din,
   input  wire                         awaiting,
   output logic                        frame_done,
   output logic                        frame_err,
   output logic [`MBUS_ADDR_WIDTH-1:0] frame_addr,
   output logic [`MBUS_DATA_WIDTH-1:0] frame_data,
   output logic                        line_busy,
   output logic [`MBUS_ADDR_WIDTH-1:0] rx_addr,
   output logic [`MBUS_DATA_WIDTH-1:0] rx_data,
   output logic                        rx_req,
   output logic                        rx_broadcast,
   output logic                        rx_fail,
   input  wire                         rx_ack
);

   localparam int SHIFT_BITS = `MBUS_FRAME_BITS - 1;
   localparam int CNT_W      = $clog2(`MBUS_FRAME_BITS);

   mbus_rx_state_t              state;
   logic [CNT_W-1:0]            bit_cnt;
   logic [SHIFT_BITS-1:0]       shreg;
   logic [`MBUS_DYNA_WIDTH-1:0] short_addr;
   logic                        short_valid;
   logic                        frame_ok;
   logic                        is_bcast;
   logic                        deliver;
   mbus_cmd_t                   cmd;

   // ==================================================
   // framing
   // ==================================================
   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         state   <= RX_IDLE;
         bit_cnt <= '0;
      end else begin
         case (state)
            RX_IDLE, RX_DONE: begin
               if (!din) begin                   // start bit, stop may be followed directly
                  state   <= RX_SHIFTING;
                  bit_cnt <= '0;
               end else begin
                  state <= RX_IDLE;
               end
            end
            RX_SHIFTING: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == CNT_W'(SHIFT_BITS - 1)) state <= RX_DONE;
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_in) begin
      if (state == RX_SHIFTING) shreg <= {shreg[SHIFT_BITS-2:0], din};
   end

   assign frame_done = (state == RX_DONE);
   assign frame_err  = frame_done && !shreg[0];  // stop bit sampled as 0
   assign frame_addr = shreg[SHIFT_BITS-1 -: `MBUS_ADDR_WIDTH];
   assign frame_data = shreg[`MBUS_DATA_WIDTH:1];
   assign line_busy  = (state != RX_IDLE) || !din;

   // our own returning frame belongs to tx_result, not to the layer
   assign frame_ok = frame_done && !frame_err && !awaiting;
   assign is_bcast = (frame_addr[7:4] == `MBUS_BCAST_PREFIX);
   assign deliver  = frame_ok && (is_bcast || (short_valid && frame_addr[7:4] == short_addr));
   assign cmd      = mbus_cmd_t'(frame_data[31:28]);

   // ==================================================
   // enumeration and delivery
   // ==================================================
   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         short_addr  <= '0;
         short_valid <= 1'b0;
      end else if (frame_ok && frame_addr == {`MBUS_BCAST_PREFIX, 4'h0}) begin
         if (cmd == CMD_ENUM && frame_data[27:8] == ADDRESS && frame_data[3:0] != 4'hF) begin
            short_addr  <= frame_data[3:0];
            short_valid <= 1'b1;
         end else if (cmd == CMD_INVAL) begin
            short_valid <= 1'b0;              // applies to every layer on the ring
         end
      end
   end

   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         rx_req  <= 1'b0;
         rx_fail <= 1'b0;
      end else begin
         rx_fail <= 1'b0;
         if (rx_req && rx_ack) rx_req <= 1'b0;
         if (deliver) begin
            if (rx_req) rx_fail <= 1'b1;      // previous frame still pending, drop this one
            else rx_req <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_in) begin
      if (deliver && !rx_req) begin
         rx_addr      <= frame_addr;
         rx_data      <= frame_data;
         rx_broadcast <= is_bcast;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/mbus_tx_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mbus_defines.svh"

module mbus_tx_engine
   import mbus_pkg::*;
(
   input  wire                         clk_in,
   input  wire                         rst_n,
   input  wire  [`MBUS_ADDR_WIDTH-1:0] tx_addr,
   input  wire  [`MBUS_DATA_WIDTH-1:0] tx_data,
   input  wire                         tx_req,
   input  wire                         line_busy,
   input  wire                         result_busy,
   output logic                        tx_ack,
   output logic                        tx_active,
   output logic                        tx_bit,
   output logic [`MBUS_ADDR_WIDTH-1:0] sent_addr,
   output logic [`MBUS_DATA_WIDTH-1:0] sent_data,
   output logic                        sent_pulse
);

   localparam int SHIFT_BITS = `MBUS_FRAME_BITS - 1;
   localparam int CNT_W      = $clog2(`MBUS_FRAME_BITS);

   mbus_tx_state_t        state;
   logic [CNT_W-1:0]      bit_cnt;
   logic [SHIFT_BITS-1:0] shreg;
   logic                  accept;

   assign accept     = (state == TX_IDLE) && tx_req && !line_busy && !result_busy;
   assign tx_active  = (state == TX_SENDING) || accept;
   assign tx_bit     = (state == TX_SENDING) ? shreg[SHIFT_BITS-1] : 1'b0;  // start bit on accept
   assign sent_pulse = (state == TX_SENDING) && (bit_cnt == CNT_W'(SHIFT_BITS - 1));

   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         state   <= TX_IDLE;
         bit_cnt <= '0;
         tx_ack  <= 1'b0;
      end else begin
         tx_ack <= accept;
         case (state)
            TX_IDLE: begin
               if (accept) begin
                  state   <= TX_SENDING;
                  bit_cnt <= '0;
               end
            end
            TX_SENDING: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (sent_pulse) state <= TX_IDLE;
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // the sent copy stays put until the next accept, which tx_result holds off
   always_ff @(posedge clk_in) begin
      if (accept) begin
         shreg     <= {tx_addr, tx_data, 1'b1};
         sent_addr <= tx_addr;
         sent_data <= tx_data;
      end else if (state == TX_SENDING) begin
         shreg <= {shreg[SHIFT_BITS-2:0], 1'b1};
      end
   end

endmodule

`default_nettype wire

// ==== rtl/mbus_tx_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mbus_defines.svh"

module mbus_tx_result
   import mbus_pkg::*;
(
   input  wire                         clk_in,
   input  wire                         rst_n,
   input  wire                         sent_pulse,
   input  wire  [`MBUS_ADDR_WIDTH-1:0] sent_addr,
   input  wire  [`MBUS_DATA_WIDTH-1:0] sent_data,
   input  wire                         frame_done,
   input  wire                         frame_err,
   input  wire  [`MBUS_ADDR_WIDTH-1:0] frame_addr,
   input  wire  [`MBUS_DATA_WIDTH-1:0] frame_data,
   input  wire                         tx_resp_ack,
   output logic                        awaiting,
   output logic                        result_busy,
   output logic                        tx_succ,
   output logic                        tx_fail
);

   localparam int WINDOW  = `MBUS_RESP_WINDOW;
   localparam int TIMER_W = $clog2(WINDOW);

   mbus_res_state_t    state;
   logic [TIMER_W-1:0] timer;
   logic               match;

   assign awaiting    = (state == RES_WAITING);
   assign result_busy = (state != RES_IDLE) || sent_pulse;
   assign match       = !frame_err && frame_addr == sent_addr && frame_data == sent_data;

   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         state   <= RES_IDLE;
         timer   <= '0;
         tx_succ <= 1'b0;
         tx_fail <= 1'b0;
      end else begin
         case (state)
            RES_IDLE: begin
               if (sent_pulse) begin
                  state <= RES_WAITING;
                  timer <= '0;
               end
            end
            RES_WAITING: begin
               timer <= timer + 1'b1;
               if (frame_done) begin            // first frame back is taken as ours
                  tx_succ <= match;
                  tx_fail <= !match;
                  state   <= RES_REPORT;
               end else if (timer == TIMER_W'(WINDOW - 1)) begin
                  tx_fail <= 1'b1;
                  state   <= RES_REPORT;
               end
            end
            RES_REPORT: begin
               if (tx_resp_ack) begin
                  tx_succ <= 1'b0;
                  tx_fail <= 1'b0;
                  state   <= RES_IDLE;
               end
            end
            default: state <= RES_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rtl/mbus_wire_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbus_wire_ctrl (
   input  wire  clk_in,
   input  wire  rst_n,
   input  wire  din,
   input  wire  tx_active,
   input  wire  tx_bit,
   input  wire  awaiting,
   output logic dout
);

   // ==================================================
   // output line
   // ==================================================
   // every path goes through one flop, so din reaches dout a cycle late
   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         dout <= 1'b1;                         // idle line is high
      end else if (tx_active) begin
         dout <= tx_bit;
      end else if (awaiting) begin
         dout <= 1'b1;                         // swallow our own frame on its way back
      end else begin
         dout <= din;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/mbus_layer_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mbus_defines.svh"

module mbus_layer_wrapper #(
   parameter logic [19:0] ADDRESS = 20'h12345
) (
   input  wire                         clk_in,
   input  wire                         rst_n,
   input  wire                         din,
   output logic                        dout,
   input  wire  [`MBUS_ADDR_WIDTH-1:0] tx_addr,
   input  wire  [`MBUS_DATA_WIDTH-1:0] tx_data,
   input  wire                         tx_req,
   output logic                        tx_ack,
   output logic [`MBUS_ADDR_WIDTH-1:0] rx_addr,
   output logic [`MBUS_DATA_WIDTH-1:0] rx_data,
   output logic                        rx_req,
   input  wire                         rx_ack,
   output logic                        rx_broadcast,
   output logic                        rx_fail,
   output logic                        tx_succ,
   output logic                        tx_fail,
   input  wire                         tx_resp_ack
);

   logic                        frame_done;
   logic                        frame_err;
   logic [`MBUS_ADDR_WIDTH-1:0] frame_addr;
   logic [`MBUS_DATA_WIDTH-1:0] frame_data;
   logic                        line_busy;
   logic                        tx_active;
   logic                        tx_bit;
   logic [`MBUS_ADDR_WIDTH-1:0] sent_addr;
   logic [`MBUS_DATA_WIDTH-1:0] sent_data;
   logic                        sent_pulse;
   logic                        awaiting;
   logic                        result_busy;

   // ==================================================
   // decode, execute, result, line
   // ==================================================
   mbus_rx_decode #(.ADDRESS(ADDRESS)) i_rx_decode (
      .clk_in       (clk_in),
      .rst_n        (rst_n),
      .din          (din),
      .awaiting     (awaiting),
      .frame_done   (frame_done),
      .frame_err    (frame_err),
      .frame_addr   (frame_addr),
      .frame_data   (frame_data),
      .line_busy    (line_busy),
      .rx_addr      (rx_addr),
      .rx_data      (rx_data),
      .rx_req       (rx_req),
      .rx_broadcast (rx_broadcast),
      .rx_fail      (rx_fail),
      .rx_ack       (rx_ack)
   );

   mbus_tx_engine i_tx_engine (
      .clk_in      (clk_in),
      .rst_n       (rst_n),
      .tx_addr     (tx_addr),
      .tx_data     (tx_data),
      .tx_req      (tx_req),
      .line_busy   (line_busy),
      .result_busy (result_busy),
      .tx_ack      (tx_ack),
      .tx_active   (tx_active),
      .tx_bit      (tx_bit),
      .sent_addr   (sent_addr),
      .sent_data   (sent_data),
      .sent_pulse  (sent_pulse)
   );

   mbus_tx_result i_tx_result (
      .clk_in      (clk_in),
      .rst_n       (rst_n),
      .sent_pulse  (sent_pulse),
      .sent_addr   (sent_addr),
      .sent_data   (sent_data),
      .frame_done  (frame_done),
      .frame_err   (frame_err),
      .frame_addr  (frame_addr),
      .frame_data  (frame_data),
      .tx_resp_ack (tx_resp_ack),
      .awaiting    (awaiting),
      .result_busy (result_busy),
      .tx_succ     (tx_succ),
      .tx_fail     (tx_fail)
   );

   mbus_wire_ctrl i_wire_ctrl (
      .clk_in    (clk_in),
      .rst_n     (rst_n),
      .din       (din),
      .tx_active (tx_active),
      .tx_bit    (tx_bit),
      .awaiting  (awaiting),
      .dout      (dout)
   );

endmodule

`default_nettype wire

// ==== tb/mbus_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbus_clk_gen #(
   parameter int PERIOD_NS = 8
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(PERIOD_NS / 2.0) clk = ~clk;  // free running until the testbench ends the run

endmodule

`default_nettype wire

// ==== tb/mbus_layer_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mbus_defines.svh"

module mbus_layer_props (
   input wire                        clk_in,
   input wire                        rst_n,
   input wire                        tx_req,
   input wire                        tx_ack,
   input wire                        rx_req,
   input wire                        rx_ack,
   input wire [`MBUS_ADDR_WIDTH-1:0] rx_addr,
   input wire [`MBUS_DATA_WIDTH-1:0] rx_data,
   input wire                        tx_succ,
   input wire                        tx_fail,
   input wire                        dout
);

   // ==================================================
   // handshakes
   // ==================================================
   // tx_ack is registered, so it answers the request seen one edge earlier
   ack_needs_req: assert property (@(posedge clk_in) disable iff (!rst_n)
      tx_ack |-> $past(tx_req))
      else $error("tx_ack without a pending tx_req");

   rx_held_stable: assert property (@(posedge clk_in) disable iff (!rst_n)
      rx_req && !rx_ack |=> rx_req && $stable(rx_addr) && $stable(rx_data))
      else $error("rx frame changed or withdrawn before rx_ack");

   result_onehot: assert property (@(posedge clk_in) disable iff (!rst_n)
      !(tx_succ && tx_fail))
      else $error("tx_succ and tx_fail high together");

   idle_after_reset: assert property (@(posedge clk_in)
      $rose(rst_n) |-> dout)
      else $error("dout not idle right after reset release");

endmodule

bind mbus_layer_wrapper mbus_layer_props i_mbus_layer_props (
   .clk_in  (clk_in),
   .rst_n   (rst_n),
   .tx_req  (tx_req),
   .tx_ack  (tx_ack),
   .rx_req  (rx_req),
   .rx_ack  (rx_ack),
   .rx_addr (rx_addr),
   .rx_data (rx_data),
   .tx_succ (tx_succ),
   .tx_fail (tx_fail),
   .dout    (dout)
);

`default_nettype wire

// ==== tb/mbus_layer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mbus_defines.svh"

module mbus_layer_tb;

   localparam int FRAME   = `MBUS_FRAME_BITS;
   localparam int STR_W   = 8 * 16;
   localparam int ACK_TMO = 64;
   localparam int RES_TMO = `MBUS_RESP_WINDOW + 32;

   logic                        clk_in;
   logic                        rst_n;
   logic                        din;
   logic                        dout;
   logic [`MBUS_ADDR_WIDTH-1:0] tx_addr;
   logic [`MBUS_DATA_WIDTH-1:0] tx_data;
   logic                        tx_req;
   logic                        tx_ack;
   logic [`MBUS_ADDR_WIDTH-1:0] rx_addr;
   logic [`MBUS_DATA_WIDTH-1:0] rx_data;
   logic                        rx_req;
   logic                        rx_ack;
   logic                        rx_broadcast;
   logic                        rx_fail;
   logic                        tx_succ;
   logic                        tx_fail;
   logic                        tx_resp_ack;
   logic [STR_W-1:0]            test_name;
   logic [`MBUS_ADDR_WIDTH-1:0] held_addr;
   logic [`MBUS_DATA_WIDTH-1:0] held_data;

   mbus_clk_gen #(.PERIOD_NS(8)) i_clk_gen (.clk(clk_in));

   mbus_layer_wrapper #(.ADDRESS(20'h12345)) i_mbus_layer_wrapper (
      .clk_in       (clk_in),
      .rst_n        (rst_n),
      .din          (din),
      .dout         (dout),
      .tx_addr      (tx_addr),
      .tx_data      (tx_data),
      .tx_req       (tx_req),
      .tx_ack       (tx_ack),
      .rx_addr      (rx_addr),
      .rx_data      (rx_data),
      .rx_req       (rx_req),
      .rx_ack       (rx_ack),
      .rx_broadcast (rx_broadcast),
      .rx_fail      (rx_fail),
      .tx_succ      (tx_succ),
      .tx_fail      (tx_fail),
      .tx_resp_ack  (tx_resp_ack)
   );

   // ==================================================
   // helpers
   // ==================================================
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         abort_run($sformatf("FAIL %0s %0s: expected %0h, actual %0h",
                             test_name, name, expected, actual));
      end
   endtask

   task automatic tick();
      @(posedge clk_in);
      #1;                                // outputs have settled and inputs change away from the edge
   endtask

   // bit FRAME-1 is the start bit and goes on the wire first
   function automatic logic [FRAME-1:0] make_frame(input logic [7:0] addr,
                                                   input logic [31:0] data);
      return {1'b0, addr, data, 1'b1};
   endfunction

   task automatic send_frame(input logic [FRAME-1:0] frame, input bit swallow);
      for (int i = FRAME - 1; i >= 0; i--) begin
         din = frame[i];
         tick();
         if (swallow)
            check_value("dout swallowed", 1, dout);
         else
            check_value("dout forwarded", frame[i], dout);
      end
      din = 1'b1;
   endtask

   task automatic ack_rx();
      rx_ack = 1'b1;
      tick();
      rx_ack = 1'b0;
      check_value("rx_req dropped", 0, rx_req);
   endtask

   task automatic ack_result();
      tx_resp_ack = 1'b1;
      tick();
      tx_resp_ack = 1'b0;
      check_value("result cleared", 0, {tx_succ, tx_fail});
   endtask

   // ==================================================
   // receive side
   // ==================================================
   task automatic run_rx(input logic [7:0] addr, input logic [31:0] data, input bit hold,
                         input bit exp_req, input bit exp_bcast, input bit exp_fail);
      send_frame(make_frame(addr, data), 1'b0);
      tick();                            // rx_req follows the stop bit by one cycle
      check_value("rx_fail", exp_fail, rx_fail);
      if (exp_fail) begin
         check_value("rx_req held", 1, rx_req);
         check_value("rx_addr held", held_addr, rx_addr);
         check_value("rx_data held", held_data, rx_data);
         ack_rx();
         repeat (4) begin
            tick();
            check_value("rx_req after drop", 0, rx_req);
         end
      end else begin
         check_value("rx_req", exp_req, rx_req);
         if (exp_req) begin
            check_value("rx_addr", addr, rx_addr);
            check_value("rx_data", data, rx_data);
            check_value("rx_broadcast", exp_bcast, rx_broadcast);
            held_addr = addr;
            held_data = data;
            if (!hold) begin
               repeat ($urandom % 5) tick();
               ack_rx();
            end
         end
      end
   endtask

   // ==================================================
   // transmit side with the testbench as the rest of the ring
   // ==================================================
   task automatic transmit(input logic [STR_W-1:0] mode, input bit exp_fail);
      logic [FRAME-1:0] cap;
      int               n;
      int               idx;
      n = 0;
      do begin
         tick();
         n++;
         if (n > ACK_TMO) abort_run("timeout: tx_req was never acknowledged");
      end while (!tx_ack);
      tx_req = 1'b0;
      cap[FRAME-1] = dout;               // start bit leaves together with tx_ack
      for (int i = FRAME - 2; i >= 0; i--) begin
         tick();
         cap[i] = dout;
      end
      check_value("start bit", 0, cap[FRAME-1]);
      check_value("stop bit", 1, cap[0]);
      check_value("sent addr", tx_addr, cap[FRAME-2 -: `MBUS_ADDR_WIDTH]);
      check_value("sent data", tx_data, cap[`MBUS_DATA_WIDTH:1]);
      if (mode == "corrupt") begin
         idx = 1 + int'($urandom % `MBUS_DATA_WIDTH);
         cap[idx] = !cap[idx];
      end else if (mode == "badstop") begin
         cap[0] = 1'b0;
      end
      if (mode != "drop") send_frame(cap, 1'b1);
      n = 0;
      do begin
         tick();
         n++;
         if (n > RES_TMO) abort_run("timeout: neither tx_succ nor tx_fail rose");
      end while (!(tx_succ || tx_fail));
      check_value("tx_succ", !exp_fail, tx_succ);
      check_value("tx_fail", exp_fail, tx_fail);
      check_value("rx_req after return", 0, rx_req);
      if (mode == "drop") check_value("window expired", 1, n >= `MBUS_RESP_WINDOW);
   endtask

   task automatic run_tx(input logic [7:0] addr, input logic [31:0] data,
                         input logic [STR_W-1:0] mode, input bit exp_fail);
      int gap;
      tx_addr = addr;
      tx_data = data;
      tx_req  = 1'b1;
      transmit(mode, exp_fail);
      // the repeated request has to wait for tx_resp_ack
      gap    = 2 + int'($urandom % 6);
      tx_req = 1'b1;
      repeat (gap) begin
         tick();
         check_value("tx_ack while result pending", 0, tx_ack);
         check_value("result held", {!exp_fail, exp_fail}, {tx_succ, tx_fail});
      end
      ack_result();
      transmit("loop", 1'b0);
      ack_result();
   endtask

   // ==================================================
   // main sequence
   // ==================================================
   initial begin
      int                          fd;
      int                          r;
      int                          e_req;
      int                          e_bcast;
      int                          e_fail;
      logic [STR_W-1:0]            name_buf;
      logic [STR_W-1:0]            kind_buf;
      logic [STR_W-1:0]            mode_buf;
      logic [8*160-1:0]            skip_buf;
      logic [`MBUS_ADDR_WIDTH-1:0] addr;
      logic [`MBUS_DATA_WIDTH-1:0] data;
      rst_n       = 1'b0;
      din         = 1'b1;
      tx_addr     = '0;
      tx_data     = '0;
      tx_req      = 1'b0;
      rx_ack      = 1'b0;
      tx_resp_ack = 1'b0;
      held_addr   = '0;
      held_data   = '0;
      test_name   = "reset";
      void'($urandom(32'h313c));
      fd = $fopen("tb/mbus_layer_tests.txt", "r");
      if (fd == 0) abort_run("could not open tb/mbus_layer_tests.txt");
      repeat (8) @(posedge clk_in);
      #1;
      rst_n = 1'b1;
      check_value("dout idle", 1, dout);
      check_value("outputs after reset", 0, {tx_ack, rx_req, rx_fail, tx_succ, tx_fail});
      tick();
      r = $fscanf(fd, "%s", name_buf);
      while (r == 1) begin
         if (name_buf == "#") begin
            r = $fgets(skip_buf, fd);
         end else begin
            test_name = name_buf;
            r = $fscanf(fd, "%s %h %h %s %d %d %d", kind_buf, addr, data, mode_buf,
                        e_req, e_bcast, e_fail);
            if (r != 7) abort_run($sformatf("record %0s is incomplete", name_buf));
            repeat (2 + $urandom % 6) tick();
            if (kind_buf == "TX")
               run_tx(addr, data, mode_buf, e_fail != 0);
            else if (kind_buf == "RX" || kind_buf == "ENUM")
               run_rx(addr, data, mode_buf == "drop", e_req != 0, e_bcast != 0, e_fail != 0);
            else
               abort_run($sformatf("record %0s has an unknown kind", name_buf));
         end
         r = $fscanf(fd, "%s", name_buf);
      end
      $fclose(fd);
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/mbus_layer_tests.txt ====
# name kind addr data ring rx_req rx_broadcast fail (rx_fail for RX and ENUM, tx_fail for TX)
# ring drop on RX holds the frame without rx_ack, badstop returns a 0 stop bit
fwd_other      RX    37 deadbeef loop    0 0 0
enum_other     ENUM  f0 25432107 loop    1 1 0
dir_other      RX    7a 00c0ffee loop    0 0 0
enum_self      ENUM  f0 21234505 loop    1 1 0
enum_short_f   ENUM  f0 2123450f loop    1 1 0
dir_five       RX    5c 0badf00d loop    1 0 0
bcast_any      RX    f3 13572468 loop    1 1 0
ovf_first      RX    51 a5a5a5a5 drop    1 0 0
ovf_second     RX    52 5a5a5a5a loop    0 0 1
inval_all      ENUM  f0 30000000 loop    1 1 0
dir_after      RX    5c 11111111 loop    0 0 0
tx_loop        TX    f1 cafef00d loop    0 0 0
tx_corrupt     TX    42 89abcdef corrupt 0 0 1
tx_badstop     TX    77 01234567 badstop 0 0 1
tx_drop        TX    3e fedcba98 drop    0 0 1
tx_again       TX    09 00000001 loop    0 0 0

// ==== mbus_layer.f ====
+incdir+include
rtl/mbus_pkg.sv
rtl/mbus_rx_decode.sv
rtl/mbus_tx_engine.sv
rtl/mbus_tx_result.sv
rtl/mbus_wire_ctrl.sv
rtl/mbus_layer_wrapper.sv
tb/mbus_clk_gen.sv
tb/mbus_layer_props.sv
tb/mbus_layer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the mbus layer testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f mbus_layer.f \
   --top-module mbus_layer_tb -o mbus_layer_sim || exit 1

./obj_dir/mbus_layer_sim | tee /dev/stderr | grep -q "TB PASSED" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
